/* verilog/read_data_mux_settings.svh */
`ifndef READ_DATA_MUX_SETTINGS_SVH
`define READ_DATA_MUX_SETTINGS_SVH

// ------------------------------
// readout geometry
// ------------------------------

// roic channel memories read per line
`define RDM_NUM_CH 12
// words taken from each channel per line
`define RDM_WORDS_PER_CH 128

// ------------------------------
// sync hold lengths
// ------------------------------

// line sync stays up this long after the last word
`define RDM_HSYNC_HOLD 6
// frame sync stays up this long after the last line
`define RDM_VSYNC_HOLD 16

// ------------------------------
// latencies
// ------------------------------

// request to data at the memory outputs
`define RDM_MEM_LATENCY 2
// sampled FSM_read_index rise to read_frame_reset
`define RDM_FRAME_RESET_DELAY 5

`endif

/* verilog/read_data_mux_pkg.sv */
package read_data_mux_pkg;

    // ------------------------------
    // data path types
    // ------------------------------

    // one 24-bit roic word, used for both the a and b halves
    typedef logic [23:0] roic_word_t;

    // one-hot channel select, one bit per roic channel memory
    // width follows the channel count of the readout
    typedef logic [11:0] ch_sel_t;

    // ------------------------------
    // counter types
    // ------------------------------

    // word index inside one channel
    // 128 words per channel, wraps back to zero after the last one
    typedef logic [6:0] word_cnt_t;

    // line index inside one frame
    // compared against the low bits of dsp_image_height
    typedef logic [11:0] line_cnt_t;

endpackage

/* verilog/line_sequencer.sv */
`timescale 1ns/1ps
`include "read_data_mux_settings.svh"

module line_sequencer
    import read_data_mux_pkg::*;
(
    input  logic        eim_clk,
    input  logic        rst_n_eim,
    input  logic        FSM_read_index,
    input  logic        FSM_aed_read_index,
    input  logic        read_data_start,
    input  logic [15:0] dsp_image_height,
    input  logic        read_axis_tready,
    input  logic        valid_read_mem,
    input  logic        csi_done,
    input  logic        line_done,
    output logic        frame_clear,
    output logic        line_start,
    output logic        word_strobe,
    output logic        frame_first,
    output logic        read_frame_reset
);

    localparam int HCNT_W = $clog2(`RDM_HSYNC_HOLD + 1);
    localparam int VCNT_W = $clog2(`RDM_VSYNC_HOLD + 1);
    localparam int OPEN_W = `RDM_FRAME_RESET_DELAY;

    logic [1:0]        read_index_d;
    logic [OPEN_W-1:0] open_sr;
    logic              hsync;
    logic [HCNT_W-1:0] hold_cnt;
    logic              hsync_drop;
    logic              vsync;
    logic [VCNT_W-1:0] vhold_cnt;
    line_cnt_t         line_cnt;
    line_cnt_t         line_next;
    logic              accept;

    // ------------------------------
    // frame open
    // ------------------------------

    // rise of the sampled read index, skipped during aed reads
    assign frame_clear = read_index_d[0] & ~read_index_d[1] & ~FSM_aed_read_index;

    // frame reset comes out of the end of the open chain
    assign read_frame_reset = open_sr[OPEN_W-1];

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            read_index_d <= '0;
            open_sr      <= '0;
        end else begin
            read_index_d <= {read_index_d[0], FSM_read_index};
            // one stage per cycle of frame reset delay
            open_sr      <= {open_sr[OPEN_W-2:0], frame_clear};
        end
    end

    // ------------------------------
    // line sync
    // ------------------------------

    // new line only inside an open frame, between lines, before the tail hold
    assign accept     = read_data_start & vsync & ~hsync & (vhold_cnt == '0);
    assign hsync_drop = (hold_cnt == HCNT_W'(1));

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            hsync      <= 1'b0;
            hold_cnt   <= '0;
            line_start <= 1'b0;
        end else begin
            line_start <= accept & ~frame_clear;
            if (frame_clear) begin
                hsync    <= 1'b0;
                hold_cnt <= '0;
            end else if (accept) begin
                hsync <= 1'b1;
            end else if (line_done && hsync) begin
                // last word requested, count down the tail
                hold_cnt <= HCNT_W'(`RDM_HSYNC_HOLD - 1);
            end else if (hsync_drop) begin
                hsync    <= 1'b0;
                hold_cnt <= '0;
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    // requests only while every upstream/downstream party is ready
    assign word_strobe = hsync & read_axis_tready & valid_read_mem & csi_done;

    // ------------------------------
    // line count and frame sync
    // ------------------------------

    assign line_next = line_cnt + 1'b1;

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            vsync     <= 1'b0;
            vhold_cnt <= '0;
            line_cnt  <= '0;
        end else if (frame_clear) begin
            vsync     <= 1'b1;
            vhold_cnt <= '0;
            line_cnt  <= '0;
        end else if (hsync_drop) begin
            line_cnt <= line_next;
            // frame full, start the frame sync tail
            if (16'(line_next) == dsp_image_height) begin
                vhold_cnt <= VCNT_W'(`RDM_VSYNC_HOLD);
            end
        end else if (vhold_cnt == VCNT_W'(1)) begin
            vsync     <= 1'b0;
            vhold_cnt <= '0;
        end else if (vhold_cnt != '0) begin
            vhold_cnt <= vhold_cnt - 1'b1;
        end
    end

    // marks requests of the first line of a frame
    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            frame_first <= 1'b0;
        end else if (frame_clear) begin
            frame_first <= 1'b1;
        end else if (line_done) begin
            frame_first <= 1'b0;
        end
    end

endmodule

/* verilog/channel_slot.sv */
`timescale 1ns/1ps
`include "read_data_mux_settings.svh"

module channel_slot
    import read_data_mux_pkg::*;
(
    input  logic eim_clk,
    input  logic rst_n_eim,
    input  logic frame_clear,
    input  logic start,
    input  logic word_strobe,
    output logic req,
    output logic done
);

    localparam word_cnt_t LAST_WORD = word_cnt_t'(`RDM_WORDS_PER_CH - 1);

    logic      active;
    word_cnt_t word_cnt;

    // ------------------------------
    // request and hand-off
    // ------------------------------

    // request in the same cycle as the strobe
    assign req = active & word_strobe;

    // last word of this channel, next slot takes over
    assign done = req & (word_cnt == LAST_WORD);

    // ------------------------------
    // active flag and word counter
    // ------------------------------

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            active <= 1'b0;
        end else if (frame_clear) begin
            active <= 1'b0;
        end else if (done) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end
    end

    // holds under back-pressure, wraps to zero after the last word
    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            word_cnt <= '0;
        end else if (frame_clear) begin
            word_cnt <= '0;
        end else if (req) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

endmodule

/* verilog/output_mux.sv */
`timescale 1ns/1ps
`include "read_data_mux_settings.svh"

module output_mux
    import read_data_mux_pkg::*;
(
    input  logic       eim_clk,
    input  logic       rst_n_eim,
    input  logic       frame_clear,
    input  ch_sel_t    req,
    input  logic       line_last,
    input  logic       frame_first,
    input  roic_word_t roic_read_data_a [`RDM_NUM_CH],
    input  roic_word_t roic_read_data_b [`RDM_NUM_CH],
    output roic_word_t read_data_out_a,
    output roic_word_t read_data_out_b,
    output logic       read_data_valid,
    output logic       read_axis_tlast,
    output logic       read_frame_start
);

    localparam int LAT = `RDM_MEM_LATENCY;

    ch_sel_t          sel_pipe [LAT];
    logic [LAT-1:0]   last_pipe;
    logic [LAT-1:0]   first_pipe;
    ch_sel_t          sel_now;
    roic_word_t       mux_a;
    roic_word_t       mux_b;
    logic             start_sent;

    // ------------------------------
    // request delay
    // ------------------------------

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            for (int k = 0; k < LAT; k++) begin
                sel_pipe[k] <= '0;
            end
            last_pipe  <= '0;
            first_pipe <= '0;
        end else if (frame_clear) begin
            for (int k = 0; k < LAT; k++) begin
                sel_pipe[k] <= '0;
            end
            last_pipe  <= '0;
            first_pipe <= '0;
        end else begin
            sel_pipe[0] <= req;
            for (int k = 1; k < LAT; k++) begin
                sel_pipe[k] <= sel_pipe[k-1];
            end
            // flags ride along with the select
            last_pipe  <= {last_pipe[LAT-2:0], line_last};
            first_pipe <= {first_pipe[LAT-2:0], frame_first & (|req)};
        end
    end

    // select lines up with the memory data here
    assign sel_now = sel_pipe[LAT-1];

    // one-hot or-mux, zero when nothing selected
    always_comb begin
        mux_a = '0;
        mux_b = '0;
        for (int k = 0; k < `RDM_NUM_CH; k++) begin
            if (sel_now[k]) begin
                mux_a = mux_a | roic_read_data_a[k];
                mux_b = mux_b | roic_read_data_b[k];
            end
        end
    end

    // ------------------------------
    // output stage
    // ------------------------------

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            read_data_out_a  <= '0;
            read_data_out_b  <= '0;
            read_data_valid  <= 1'b0;
            read_axis_tlast  <= 1'b0;
            read_frame_start <= 1'b0;
            start_sent       <= 1'b0;
        end else if (frame_clear) begin
            read_data_out_a  <= '0;
            read_data_out_b  <= '0;
            read_data_valid  <= 1'b0;
            read_axis_tlast  <= 1'b0;
            read_frame_start <= 1'b0;
            start_sent       <= 1'b0;
        end else begin
            read_data_out_a  <= mux_a;
            read_data_out_b  <= mux_b;
            read_data_valid  <= |sel_now;
            read_axis_tlast  <= last_pipe[LAT-1];
            // only the first word of the frame carries frame start
            read_frame_start <= first_pipe[LAT-1] & ~start_sent;
            if (first_pipe[LAT-1]) begin
                start_sent <= 1'b1;
            end
        end
    end

endmodule

/* verilog/read_data_mux_top.sv */
`timescale 1ns/1ps
`include "read_data_mux_settings.svh"

module read_data_mux_top
    import read_data_mux_pkg::*;
(
    input  logic        eim_clk,
    input  logic        rst_n_eim,
    input  logic        csi_done,
    input  logic [15:0] dsp_image_height,
    input  logic        FSM_aed_read_index,
    input  logic        FSM_read_index,
    input  logic        read_data_start,
    input  roic_word_t  roic_read_data_a [`RDM_NUM_CH],
    input  roic_word_t  roic_read_data_b [`RDM_NUM_CH],
    input  logic        valid_read_mem,
    input  logic        read_axis_tready,
    output logic        read_axis_tlast,
    output logic        read_data_valid,
    output roic_word_t  read_data_out_a,
    output roic_word_t  read_data_out_b,
    output logic        read_frame_start,
    output logic        read_frame_reset,
    output ch_sel_t     data_read_req
);

    logic    frame_clear;
    logic    line_start;
    logic    word_strobe;
    logic    frame_first;
    ch_sel_t slot_start;
    ch_sel_t slot_done;

    // ------------------------------
    // frame and line control
    // ------------------------------

    line_sequencer i_line_sequencer (
        .eim_clk            (eim_clk),
        .rst_n_eim          (rst_n_eim),
        .FSM_read_index     (FSM_read_index),
        .FSM_aed_read_index (FSM_aed_read_index),
        .read_data_start    (read_data_start),
        .dsp_image_height   (dsp_image_height),
        .read_axis_tready   (read_axis_tready),
        .valid_read_mem     (valid_read_mem),
        .csi_done           (csi_done),
        .line_done          (slot_done[`RDM_NUM_CH-1]),
        .frame_clear        (frame_clear),
        .line_start         (line_start),
        .word_strobe        (word_strobe),
        .frame_first        (frame_first),
        .read_frame_reset   (read_frame_reset)
    );

    // ------------------------------
    // channel slots
    // ------------------------------

    // slot 0 opens the line, each later slot starts on the previous hand-off
    assign slot_start = {slot_done[`RDM_NUM_CH-2:0], line_start};

    for (genvar i = 0; i < `RDM_NUM_CH; i++) begin : gen_slot
        channel_slot i_channel_slot (
            .eim_clk     (eim_clk),
            .rst_n_eim   (rst_n_eim),
            .frame_clear (frame_clear),
            .start       (slot_start[i]),
            .word_strobe (word_strobe),
            .req         (data_read_req[i]),
            .done        (slot_done[i])
        );
    end

    // ------------------------------
    // data select and output
    // ------------------------------

    output_mux i_output_mux (
        .eim_clk          (eim_clk),
        .rst_n_eim        (rst_n_eim),
        .frame_clear      (frame_clear),
        .req              (data_read_req),
        .line_last        (slot_done[`RDM_NUM_CH-1]),
        .frame_first      (frame_first),
        .roic_read_data_a (roic_read_data_a),
        .roic_read_data_b (roic_read_data_b),
        .read_data_out_a  (read_data_out_a),
        .read_data_out_b  (read_data_out_b),
        .read_data_valid  (read_data_valid),
        .read_axis_tlast  (read_axis_tlast),
        .read_frame_start (read_frame_start)
    );

endmodule

/* dv/roic_mem_model.sv */
`timescale 1ns/1ps
`include "read_data_mux_settings.svh"

module roic_mem_model
    import read_data_mux_pkg::*;
(
    input  logic       eim_clk,
    input  logic       rst_n_eim,
    input  ch_sel_t    req,
    output roic_word_t rd_a [`RDM_NUM_CH],
    output roic_word_t rd_b [`RDM_NUM_CH]
);

    // running request count per channel, line in the upper bits
    logic [19:0] req_cnt [`RDM_NUM_CH];
    // two register stages give the fixed memory latency
    roic_word_t  stage1  [`RDM_NUM_CH];
    roic_word_t  stage2  [`RDM_NUM_CH];

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            for (int k = 0; k < `RDM_NUM_CH; k++) begin
                req_cnt[k] <= '0;
                stage1[k]  <= '0;
                stage2[k]  <= '0;
            end
        end else begin
            for (int k = 0; k < `RDM_NUM_CH; k++) begin
                stage2[k] <= stage1[k];
                if (req[k]) begin
                    // channel, line, word index
                    stage1[k]  <= {4'(k), req_cnt[k]};
                    req_cnt[k] <= req_cnt[k] + 20'd1;
                end else begin
                    stage1[k] <= '0;
                end
            end
        end
    end

    // b half is the inverse of the a half
    always_comb begin
        for (int k = 0; k < `RDM_NUM_CH; k++) begin
            rd_a[k] = stage2[k];
            rd_b[k] = ~stage2[k];
        end
    end

endmodule

/* dv/tb_read_data_mux.sv */
`timescale 1ns/1ps
`include "read_data_mux_settings.svh"

module tb_read_data_mux
    import read_data_mux_pkg::*;
();

    localparam int IMAGE_LINES    = 3;
    localparam int LINE_WORDS     = `RDM_NUM_CH * `RDM_WORDS_PER_CH;
    // three lines, slowed down up to 3x by back-pressure, plus margin
    localparam int TIMEOUT_CYCLES = IMAGE_LINES * LINE_WORDS * 3 + 2000;

    logic        eim_clk = 1'b0;
    logic        rst_n_eim;
    logic        csi_done = 1'b1;
    logic        valid_read_mem = 1'b1;
    logic        read_axis_tready = 1'b1;
    logic [15:0] dsp_image_height;
    logic        FSM_aed_read_index;
    logic        FSM_read_index;
    logic        read_data_start;
    roic_word_t  mem_a [`RDM_NUM_CH];
    roic_word_t  mem_b [`RDM_NUM_CH];
    logic        read_axis_tlast;
    logic        read_data_valid;
    roic_word_t  read_data_out_a;
    roic_word_t  read_data_out_b;
    logic        read_frame_start;
    logic        read_frame_reset;
    ch_sel_t     data_read_req;

    // checker state
    int          errors = 0;
    int          short_run = 0;
    int          cycle_cnt = 0;
    int          starts_issued = 0;
    int          lines_requested = 0;
    int          reqs_checked = 0;
    int          words_checked = 0;
    int          req_ch = 0;
    int          req_word = 0;
    int          exp_ch = 0;
    int          exp_word = 0;
    int          exp_line = 0;
    logic        bp_on = 1'b0;
    logic        read_index_prev = 1'b0;
    logic        frame_rise;
    logic        first_pending = 1'b0;
    logic [`RDM_FRAME_RESET_DELAY:0] reset_pipe = '0;
    logic [`RDM_MEM_LATENCY:0]       valid_pipe = '0;
    ch_sel_t     exp_req;
    roic_word_t  exp_a;
    roic_word_t  exp_b;
    logic        exp_last;
    logic        exp_first;

    // 20 ns period
    always #10 eim_clk = ~eim_clk;

    read_data_mux_top i_dut (
        .eim_clk            (eim_clk),
        .rst_n_eim          (rst_n_eim),
        .csi_done           (csi_done),
        .dsp_image_height   (dsp_image_height),
        .FSM_aed_read_index (FSM_aed_read_index),
        .FSM_read_index     (FSM_read_index),
        .read_data_start    (read_data_start),
        .roic_read_data_a   (mem_a),
        .roic_read_data_b   (mem_b),
        .valid_read_mem     (valid_read_mem),
        .read_axis_tready   (read_axis_tready),
        .read_axis_tlast    (read_axis_tlast),
        .read_data_valid    (read_data_valid),
        .read_data_out_a    (read_data_out_a),
        .read_data_out_b    (read_data_out_b),
        .read_frame_start   (read_frame_start),
        .read_frame_reset   (read_frame_reset),
        .data_read_req      (data_read_req)
    );

    roic_mem_model i_mem (
        .eim_clk   (eim_clk),
        .rst_n_eim (rst_n_eim),
        .req       (data_read_req),
        .rd_a      (mem_a),
        .rd_b      (mem_b)
    );

    // ------------------------------
    // helpers
    // ------------------------------

    // channel in the top bits, then running line, then word
    function automatic roic_word_t encode_word(input int ch, input int line, input int word);
        return {4'(ch), 13'(line), 7'(word)};
    endfunction

    task automatic flag_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, sig, got, want);
        errors++;
    endtask

    task automatic log_problem(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    // ------------------------------
    // checks, sampled on the rising edge
    // ------------------------------

    always @(posedge eim_clk) begin
        // frame open, aed reads do not count
        frame_rise = FSM_read_index && !read_index_prev && !FSM_aed_read_index;
        read_index_prev = FSM_read_index;
        assert (read_frame_reset == reset_pipe[`RDM_FRAME_RESET_DELAY])
            else flag_mismatch("read_frame_reset", 32'(read_frame_reset),
                               32'(reset_pipe[`RDM_FRAME_RESET_DELAY]));
        reset_pipe = {reset_pipe[`RDM_FRAME_RESET_DELAY-1:0], frame_rise};
        if (frame_rise) begin
            first_pending = 1'b1;
        end

        // requests: only inside a started line, never under back-pressure, in order
        if (|data_read_req) begin
            exp_req = ch_sel_t'(1) << req_ch;
            assert (read_axis_tready && valid_read_mem && csi_done)
                else log_problem("request issued while back-pressure was applied");
            assert (starts_issued > lines_requested)
                else log_problem("request issued with no line started");
            assert (data_read_req == exp_req)
                else flag_mismatch("data_read_req", 32'(data_read_req), 32'(exp_req));
            reqs_checked++;
            req_word++;
            if (req_word == `RDM_WORDS_PER_CH) begin
                req_word = 0;
                req_ch++;
                if (req_ch == `RDM_NUM_CH) begin
                    req_ch = 0;
                    lines_requested++;
                end
            end
        end

        // valid exactly three cycles after the request
        assert (read_data_valid == valid_pipe[`RDM_MEM_LATENCY])
            else flag_mismatch("read_data_valid", 32'(read_data_valid),
                               32'(valid_pipe[`RDM_MEM_LATENCY]));
        valid_pipe = {valid_pipe[`RDM_MEM_LATENCY-1:0], |data_read_req};

        // outputs stay zero between valid words
        exp_a     = '0;
        exp_b     = '0;
        exp_last  = 1'b0;
        exp_first = 1'b0;
        if (read_data_valid) begin
            exp_a     = encode_word(exp_ch, exp_line, exp_word);
            exp_b     = ~exp_a;
            exp_last  = (exp_ch == `RDM_NUM_CH - 1) && (exp_word == `RDM_WORDS_PER_CH - 1);
            exp_first = first_pending;
        end
        assert (read_data_out_a == exp_a)
            else flag_mismatch("read_data_out_a", 32'(read_data_out_a), 32'(exp_a));
        assert (read_data_out_b == exp_b)
            else flag_mismatch("read_data_out_b", 32'(read_data_out_b), 32'(exp_b));
        assert (read_axis_tlast == exp_last)
            else flag_mismatch("read_axis_tlast", 32'(read_axis_tlast), 32'(exp_last));
        assert (read_frame_start == exp_first)
            else flag_mismatch("read_frame_start", 32'(read_frame_start), 32'(exp_first));

        if (read_data_valid) begin
            first_pending = 1'b0;
            words_checked++;
            exp_word++;
            if (exp_word == `RDM_WORDS_PER_CH) begin
                exp_word = 0;
                exp_ch++;
                if (exp_ch == `RDM_NUM_CH) begin
                    exp_ch = 0;
                    exp_line++;
                end
            end
        end
    end

    // ------------------------------
    // back-pressure and timeout
    // ------------------------------

    // each ready drops about one cycle in ten
    always @(negedge eim_clk) begin
        if (bp_on) begin
            read_axis_tready = ($urandom % 10) != 0;
            valid_read_mem   = ($urandom % 10) != 0;
            csi_done         = ($urandom % 10) != 0;
        end else begin
            read_axis_tready = 1'b1;
            valid_read_mem   = 1'b1;
            csi_done         = 1'b1;
        end
    end

    always @(posedge eim_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------

    task automatic pulse_start(input logic counted);
        @(negedge eim_clk);
        read_data_start = 1'b1;
        if (counted) begin
            starts_issued++;
        end
        @(negedge eim_clk);
        read_data_start = 1'b0;
    endtask

    // open a frame, read all its lines, then try one start too many
    task automatic run_frame(input logic with_bp);
        @(negedge eim_clk);
        FSM_read_index = 1'b1;
        do begin
            @(negedge eim_clk);
        end while (!read_frame_reset);
        bp_on = with_bp;
        for (int n = 0; n < IMAGE_LINES; n++) begin
            pulse_start(1'b1);
            while (lines_requested < starts_issued) begin
                @(negedge eim_clk);
            end
            // let line sync drop before the next start
            repeat (`RDM_HSYNC_HOLD + 4) @(negedge eim_clk);
        end
        bp_on = 1'b0;
        // frame full, both starts must be ignored
        pulse_start(1'b0);
        repeat (30) @(negedge eim_clk);
        pulse_start(1'b0);
        repeat (30) @(negedge eim_clk);
        FSM_read_index = 1'b0;
        repeat (4) @(negedge eim_clk);
    endtask

    initial begin
        void'($urandom(32'h93e3_f101));
        rst_n_eim          = 1'b0;
        dsp_image_height   = 16'(IMAGE_LINES);
        FSM_aed_read_index = 1'b0;
        FSM_read_index     = 1'b0;
        read_data_start    = 1'b0;
        repeat (8) @(posedge eim_clk);
        @(negedge eim_clk);
        rst_n_eim = 1'b1;

        // start without an open frame
        repeat (5) @(negedge eim_clk);
        pulse_start(1'b0);
        repeat (40) @(negedge eim_clk);

        // rise during an aed read, no frame reset
        FSM_aed_read_index = 1'b1;
        FSM_read_index     = 1'b1;
        repeat (12) @(negedge eim_clk);
        FSM_read_index = 1'b0;
        repeat (4) @(negedge eim_clk);
        FSM_aed_read_index = 1'b0;
        repeat (4) @(negedge eim_clk);

        run_frame(1'b0);
        run_frame(1'b1);
        repeat (20) @(negedge eim_clk);

        assert (words_checked == 2 * IMAGE_LINES * LINE_WORDS)
            else begin
                $display("fewer valid words than expected: %0d", words_checked);
                short_run = 1;
            end
        $display("summary: %0d errors, %0d requests and %0d valid words checked",
                 errors + short_run, reqs_checked, words_checked);
        if (errors + short_run == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verilog
verilog/read_data_mux_pkg.sv
verilog/line_sequencer.sv
verilog/channel_slot.sv
verilog/output_mux.sv
verilog/read_data_mux_top.sv
dv/roic_mem_model.sv
dv/tb_read_data_mux.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_read_data_mux -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_read_data_mux > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
    exit 0
fi
exit 1
